//--- source/fc_pkg.sv
package fc_pkg;

  // ****************************************
  // Widths with a meaning
  // ****************************************

  // Data and address word
  typedef logic [31:0] word_t;
  // Register file index
  typedef logic [2:0]  reg_idx_t;
  // Interrupt line number
  typedef logic [4:0]  irq_id_t;
  // One bit per interrupt line
  typedef logic [31:0] irq_vec_t;

  localparam int unsigned N_IRQ  = 32;
  localparam int unsigned N_REGS = 8;

  // Whole-word access on both buses
  localparam logic [3:0] BE_ALL = 4'b1111;

  // ****************************************
  // Instruction fields
  // ****************************************
  localparam int unsigned OPC_MSB = 31;
  localparam int unsigned OPC_LSB = 28;
  localparam int unsigned RD_MSB  = 27;
  localparam int unsigned RD_LSB  = 25;
  localparam int unsigned RS1_MSB = 24;
  localparam int unsigned RS1_LSB = 22;
  localparam int unsigned RS2_MSB = 21;
  localparam int unsigned RS2_LSB = 19;
  // Immediate, sign-extended to a word
  localparam int unsigned IMM_MSB = 15;
  localparam int unsigned IMM_LSB = 0;

  // Unlisted encodings run as no-ops
  typedef enum logic [3:0] {
    OP_LI   = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_XOR  = 4'h4,
    OP_LW   = 4'h5,
    OP_SW   = 4'h6,
    OP_HALT = 4'hF
  } opcode_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IRQ,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } ctrl_state_t;

endpackage

//--- source/fc_irq_latch.sv
module fc_irq_latch import fc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  irq_vec_t events_i,
  input  logic     irq_ack_i,
  input  irq_id_t  irq_ack_id_i,
  output logic     irq_pending_o,
  output irq_id_t  irq_sel_id_o
);

  irq_vec_t irq_q;
  irq_id_t  sel_id;

  // ****************************************
  // Event sampling
  // ****************************************

  // Each line follows its event input
  // Acknowledged line is cleared instead, for that one edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= '0;
    end else begin
      for (int i = 0; i < N_IRQ; i++) begin
        if (irq_ack_i && (irq_ack_id_i == irq_id_t'(i))) begin
          irq_q[i] <= 1'b0;
        end else begin
          irq_q[i] <= events_i[i];
        end
      end
    end
  end

  // Lowest line number wins
  // Scan downwards so the last hit is the lowest
  always_comb begin
    sel_id = '0;
    for (int i = N_IRQ - 1; i >= 0; i--) begin
      if (irq_q[i]) begin
        sel_id = irq_id_t'(i);
      end
    end
  end

  assign irq_pending_o = |irq_q;
  assign irq_sel_id_o  = sel_id;

endmodule

//--- source/fc_fetch_port.sv
module fc_fetch_port import fc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // From control
  input  logic  fetch_start_i,
  input  word_t pc_i,
  // Instruction bus
  output logic  instr_req_o,
  output word_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  // To core
  output word_t instr_o,
  output logic  fetch_done_o
);

  // Request waiting for grant
  logic  req_q;
  // Granted, waiting for rvalid
  logic  pend_q;
  word_t addr_q;
  word_t instr_q;

  logic  granted;

  assign granted = req_q & instr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      // Held until the grant cycle
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      if (granted) begin
        pend_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Address and returned word
  always_ff @(posedge clk_i) begin
    if (fetch_start_i) begin
      addr_q <= pc_i;
    end
    if (instr_rvalid_i && pend_q) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;
  assign instr_o      = instr_q;
  assign fetch_done_o = instr_rvalid_i & pend_q;

endmodule

//--- source/fc_data_port.sv
module fc_data_port import fc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // From control and datapath
  input  logic       mem_start_i,
  input  logic       mem_write_i,
  input  word_t      mem_addr_i,
  input  word_t      mem_wdata_i,
  // Data bus
  output logic       data_req_o,
  output word_t      data_addr_o,
  output logic       data_wen_o,
  output word_t      data_wdata_o,
  output logic [3:0] data_be_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  word_t      data_rdata_i,
  // Back to the core
  output word_t      load_data_o,
  output logic       mem_done_o
);

  logic  req_q;
  logic  pend_q;
  // Bus write enable, low for a store
  logic  wen_q;
  word_t addr_q;
  word_t wdata_q;

  logic  granted;

  assign granted = req_q & data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      pend_q <= 1'b0;
      wen_q  <= 1'b1;
    end else begin
      if (mem_start_i) begin
        req_q <= 1'b1;
        // Core write sense flipped for the bus
        wen_q <= ~mem_write_i;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      // Reads and writes both see an rvalid
      if (granted) begin
        pend_q <= 1'b1;
      end else if (data_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Request payload, held through back-pressure
  always_ff @(posedge clk_i) begin
    if (mem_start_i) begin
      addr_q  <= mem_addr_i;
      wdata_q <= mem_wdata_i;
    end
  end

  assign data_req_o   = req_q;
  assign data_addr_o  = addr_q;
  assign data_wen_o   = wen_q;
  assign data_wdata_o = wdata_q;
  assign data_be_o    = BE_ALL;

  // Read word goes to the register file in the rvalid cycle
  assign load_data_o = data_rdata_i;
  assign mem_done_o  = data_rvalid_i & pend_q;

endmodule

//--- source/fc_exec_unit.sv
module fc_exec_unit import fc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  word_t instr_i,
  // Write strobes from control
  input  logic  alu_we_i,
  input  logic  load_we_i,
  input  word_t load_data_i,
  // To the data port
  output word_t mem_addr_o,
  output word_t store_data_o
);

  opcode_t  opcode;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_res;

  word_t    rf_q [N_REGS];

  // ****************************************
  // Decode
  // ****************************************
  assign opcode = opcode_t'(instr_i[OPC_MSB:OPC_LSB]);
  assign rd     = instr_i[RD_MSB:RD_LSB];
  assign rs1    = instr_i[RS1_MSB:RS1_LSB];
  assign rs2    = instr_i[RS2_MSB:RS2_LSB];
  assign imm    = {{16{instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

  // Register 0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  // ****************************************
  // ALU
  // ****************************************
  always_comb begin
    case (opcode)
      OP_LI:   alu_res = imm;
      OP_ADD:  alu_res = rs1_val + rs2_val;
      OP_SUB:  alu_res = rs1_val - rs2_val;
      OP_XOR:  alu_res = rs1_val ^ rs2_val;
      default: alu_res = '0;
    endcase
  end

  // Base plus offset
  assign mem_addr_o   = rs1_val + imm;
  // Store source is rs2
  assign store_data_o = rs2_val;

  // Writes to register 0 are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rd != '0) begin
      if (alu_we_i) begin
        rf_q[rd] <= alu_res;
      end else if (load_we_i) begin
        rf_q[rd] <= load_data_i;
      end
    end
  end

endmodule

//--- source/fc_core_ctrl.sv
module fc_core_ctrl import fc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    fetch_en_i,
  input  word_t   boot_addr_i,
  input  word_t   instr_i,
  // Port handshakes
  input  logic    fetch_done_i,
  input  logic    mem_done_i,
  // Interrupt latch
  input  logic    irq_pending_i,
  input  irq_id_t irq_sel_id_i,
  // Fetch side
  output logic    fetch_start_o,
  output word_t   pc_o,
  // Memory side
  output logic    mem_start_o,
  output logic    mem_write_o,
  // Register file strobes
  output logic    alu_we_o,
  output logic    load_we_o,
  // Interrupt acknowledge
  output logic    irq_ack_o,
  output irq_id_t irq_ack_id_o,
  output logic    stoptimer_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  ctrl_state_t boundary_st;

  word_t   pc_q;
  logic    fetch_start_q;

  opcode_t opcode;
  logic    is_alu;
  logic    is_mem;
  logic    is_halt;
  logic    instr_done;

  // ****************************************
  // Opcode classes
  // ****************************************
  assign opcode  = opcode_t'(instr_i[OPC_MSB:OPC_LSB]);
  assign is_alu  = (opcode == OP_LI) || (opcode == OP_ADD) ||
                   (opcode == OP_SUB) || (opcode == OP_XOR);
  assign is_mem  = (opcode == OP_LW) || (opcode == OP_SW);
  assign is_halt = (opcode == OP_HALT);

  // Take a pending interrupt between instructions
  assign boundary_st = irq_pending_i ? ST_IRQ : ST_FETCH;

  // Retire point of each instruction
  assign instr_done = ((state_q == ST_EXEC) && !is_mem && !is_halt) ||
                      ((state_q == ST_MEM) && mem_done_i);

  // ****************************************
  // Next state
  // ****************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_en_i) begin
          state_d = boundary_st;
        end
      end
      // One cycle only
      ST_IRQ:   state_d = ST_FETCH;
      ST_FETCH: begin
        if (fetch_done_i) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (is_halt) begin
          state_d = ST_HALT;
        end else if (is_mem) begin
          state_d = ST_MEM;
        end else begin
          state_d = boundary_st;
        end
      end
      ST_MEM: begin
        if (mem_done_i) begin
          state_d = boundary_st;
        end
      end
      // Left only by reset
      ST_HALT: state_d = ST_HALT;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_IDLE;
      pc_q          <= '0;
      fetch_start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulse in the first cycle of ST_FETCH, PC already stepped
      fetch_start_q <= (state_d == ST_FETCH) && (state_q != ST_FETCH);
      if ((state_q == ST_IDLE) && fetch_en_i) begin
        pc_q <= boot_addr_i;
      end else if (instr_done) begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

  assign fetch_start_o = fetch_start_q;
  assign pc_o          = pc_q;

  // Issued from EXEC, instruction word stays put through ST_MEM
  assign mem_start_o = (state_q == ST_EXEC) && is_mem;
  assign mem_write_o = (opcode == OP_SW);

  assign alu_we_o  = (state_q == ST_EXEC) && is_alu;
  assign load_we_o = (state_q == ST_MEM) && mem_done_i && (opcode == OP_LW);

  // Ack only a line still latched, latch clears it at the next edge
  assign irq_ack_o    = (state_q == ST_IRQ) && irq_pending_i;
  assign irq_ack_id_o = irq_sel_id_i;

  assign stoptimer_o = (state_q == ST_HALT);

endmodule

//--- source/fc_subsystem.sv
module fc_subsystem import fc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_en_i,
  input  word_t      boot_addr_i,
  input  irq_vec_t   events_i,
  // Instruction bus, read only
  output logic       instr_req_o,
  output word_t      instr_addr_o,
  output logic       instr_wen_o,
  output logic [3:0] instr_be_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  word_t      instr_rdata_i,
  // Data bus
  output logic       data_req_o,
  output word_t      data_addr_o,
  output logic       data_wen_o,
  output word_t      data_wdata_o,
  output logic [3:0] data_be_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  word_t      data_rdata_i,
  // Interrupt acknowledge and status
  output logic       core_irq_ack_o,
  output irq_id_t    core_irq_ack_id_o,
  output logic       stoptimer_o
);

  logic    fetch_start;
  logic    fetch_done;
  word_t   pc;
  word_t   instr;
  logic    mem_start;
  logic    mem_write;
  logic    mem_done;
  word_t   mem_addr;
  word_t   store_data;
  word_t   load_data;
  logic    alu_we;
  logic    load_we;
  logic    irq_pending;
  irq_id_t irq_sel_id;

  // Instruction port never writes
  assign instr_wen_o = 1'b1;
  assign instr_be_o  = BE_ALL;

  // ****************************************
  // Interrupts
  // ****************************************
  fc_irq_latch irq_latch_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .events_i     (events_i),
    .irq_ack_i    (core_irq_ack_o),
    .irq_ack_id_i (core_irq_ack_id_o),
    .irq_pending_o(irq_pending),
    .irq_sel_id_o (irq_sel_id)
  );

  fc_core_ctrl core_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_en_i   (fetch_en_i),
    .boot_addr_i  (boot_addr_i),
    .instr_i      (instr),
    .fetch_done_i (fetch_done),
    .mem_done_i   (mem_done),
    .irq_pending_i(irq_pending),
    .irq_sel_id_i (irq_sel_id),
    .fetch_start_o(fetch_start),
    .pc_o         (pc),
    .mem_start_o  (mem_start),
    .mem_write_o  (mem_write),
    .alu_we_o     (alu_we),
    .load_we_o    (load_we),
    .irq_ack_o    (core_irq_ack_o),
    .irq_ack_id_o (core_irq_ack_id_o),
    .stoptimer_o  (stoptimer_o)
  );

  // ****************************************
  // Datapath and bus ports
  // ****************************************
  fc_fetch_port fetch_port_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_start_i (fetch_start),
    .pc_i          (pc),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_o       (instr),
    .fetch_done_o  (fetch_done)
  );

  fc_exec_unit exec_unit_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_i     (instr),
    .alu_we_i    (alu_we),
    .load_we_i   (load_we),
    .load_data_i (load_data),
    .mem_addr_o  (mem_addr),
    .store_data_o(store_data)
  );

  fc_data_port data_port_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_start_i  (mem_start),
    .mem_write_i  (mem_write),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (store_data),
    .data_req_o   (data_req_o),
    .data_addr_o  (data_addr_o),
    .data_wen_o   (data_wen_o),
    .data_wdata_o (data_wdata_o),
    .data_be_o    (data_be_o),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .data_rdata_i (data_rdata_i),
    .load_data_o  (load_data),
    .mem_done_o   (mem_done)
  );

endmodule

//--- sim/fc_subsystem_assert.sv
module fc_subsystem_assert import fc_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  instr_req_i,
  input word_t instr_addr_i,
  input logic  instr_gnt_i,
  input logic  instr_rvalid_i,
  input logic  data_req_i,
  input word_t data_addr_i,
  input logic  data_wen_i,
  input word_t data_wdata_i,
  input logic  data_gnt_i,
  input logic  data_rvalid_i,
  input logic  irq_ack_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // ****************************************
  // Requests held until granted
  // ****************************************
  instr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or changed before its grant");

  data_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) &&
      $stable(data_wen_i) && $stable(data_wdata_i))
    else $error("data request dropped or changed before its grant");

  // Response one cycle after a grant
  instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> $past(instr_req_i && instr_gnt_i))
    else $error("instruction rvalid without a grant in the cycle before");

  data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> $past(data_req_i && data_gnt_i))
    else $error("data rvalid without a grant in the cycle before");

  // Single-cycle ack
  irq_ack_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> !irq_ack_i)
    else $error("interrupt acknowledge held longer than one cycle");

endmodule

bind fc_subsystem fc_subsystem_assert fc_subsystem_assert_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_req_i   (instr_req_o),
  .instr_addr_i  (instr_addr_o),
  .instr_gnt_i   (instr_gnt_i),
  .instr_rvalid_i(instr_rvalid_i),
  .data_req_i    (data_req_o),
  .data_addr_i   (data_addr_o),
  .data_wen_i    (data_wen_o),
  .data_wdata_i  (data_wdata_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .irq_ack_i     (core_irq_ack_o)
);

//--- sim/tb_fc_subsystem.sv
module tb_fc_subsystem import fc_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED        = 72962;
  localparam int          RST_CYCLES  = 10;
  // Random body then one store per register and a halt
  localparam int          N_RAND      = 40;
  localparam int          PROG_LEN    = N_RAND + int'(N_REGS) + 1;
  localparam int          MEM_WORDS   = 1024;
  localparam word_t       BOOT_ADDR   = 32'h0000_0400;
  localparam word_t       DATA_BASE   = 32'h0000_0800;
  // Per instruction budget plus reset and tail
  localparam int          WDOG_CYCLES = RST_CYCLES + 60 * PROG_LEN + 100;

  typedef struct packed {
    logic  wr;
    word_t addr;
    word_t data;
  } access_t;

  logic       clk_i;
  logic       rst_ni;
  logic       fetch_en_i;
  word_t      boot_addr_i;
  irq_vec_t   events_i;
  logic       instr_req_o;
  word_t      instr_addr_o;
  logic       instr_wen_o;
  logic [3:0] instr_be_o;
  logic       instr_gnt_i;
  logic       instr_rvalid_i;
  word_t      instr_rdata_i;
  logic       data_req_o;
  word_t      data_addr_o;
  logic       data_wen_o;
  word_t      data_wdata_o;
  logic [3:0] data_be_o;
  logic       data_gnt_i;
  logic       data_rvalid_i;
  word_t      data_rdata_i;
  logic       core_irq_ack_o;
  irq_id_t    core_irq_ack_id_o;
  logic       stoptimer_o;

  // L2 contents seen by the DUT and by the ISA model
  word_t   mem     [MEM_WORDS];
  word_t   ref_mem [MEM_WORDS];
  word_t   prog    [PROG_LEN];
  // Data accesses in program order
  access_t exp_q   [$];
  int      fetch_cnt = 0;

  // One generator state per process
  int unsigned prog_seed = SEED;
  int unsigned ibus_seed = SEED + 1;
  int unsigned dbus_seed = SEED + 2;
  int unsigned evt_seed  = SEED + 3;

  fc_subsystem dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_en_i       (fetch_en_i),
    .boot_addr_i      (boot_addr_i),
    .events_i         (events_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_wen_o      (instr_wen_o),
    .instr_be_o       (instr_be_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .data_req_o       (data_req_o),
    .data_addr_o      (data_addr_o),
    .data_wen_o       (data_wen_o),
    .data_wdata_o     (data_wdata_o),
    .data_be_o        (data_be_o),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_rdata_i     (data_rdata_i),
    .core_irq_ack_o   (core_irq_ack_o),
    .core_irq_ack_id_o(core_irq_ack_id_o),
    .stoptimer_o      (stoptimer_o)
  );

  // ****************************************
  // Helpers
  // ****************************************
  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t encode_instr(input opcode_t op, input reg_idx_t rd,
                                         input reg_idx_t rs1, input reg_idx_t rs2,
                                         input logic [15:0] imm);
    word_t w;
    w = '0;
    w[OPC_MSB:OPC_LSB] = op;
    w[RD_MSB:RD_LSB]   = rd;
    w[RS1_MSB:RS1_LSB] = rs1;
    w[RS2_MSB:RS2_LSB] = rs2;
    w[IMM_MSB:IMM_LSB] = imm;
    return w;
  endfunction

  function automatic int mem_index(input word_t addr);
    return int'(addr[11:2]);
  endfunction

  // Pattern mixes every address bit
  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic irq_id_t lowest_event(input irq_vec_t ev);
    for (int i = 0; i < int'(N_IRQ); i++) begin
      if (ev[i]) begin
        return irq_id_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_irq_id(input string name, input irq_id_t got, input irq_id_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %0d ns %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %0d ns %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // ****************************************
  // Program and ISA model
  // ****************************************
  task automatic build_program();
    int unsigned f;
    int unsigned r;
    opcode_t     op;
    logic [15:0] imm;
    for (int n = 0; n < N_RAND; n++) begin
      prog_seed = lcg_next(prog_seed);
      f = prog_seed;
      prog_seed = lcg_next(prog_seed);
      r = prog_seed;
      case ((f >> 26) % 6)
        0:       op = OP_LI;
        1:       op = OP_ADD;
        2:       op = OP_SUB;
        3:       op = OP_XOR;
        4:       op = OP_LW;
        default: op = OP_SW;
      endcase
      if (op == OP_LW || op == OP_SW) begin
        // Zero register base with an offset inside the data region
        imm = 16'(DATA_BASE + 4 * ((r >> 20) % 256));
        prog[n] = encode_instr(op, reg_idx_t'(f >> 16), '0, reg_idx_t'(f >> 22), imm);
      end else begin
        prog[n] = encode_instr(op, reg_idx_t'(f >> 16), reg_idx_t'(f >> 19),
                               reg_idx_t'(f >> 22), 16'(r >> 16));
      end
    end
    // Dump of every register including r0
    for (int i = 0; i < int'(N_REGS); i++) begin
      prog[N_RAND + i] = encode_instr(OP_SW, '0, '0, reg_idx_t'(i),
                                      16'(DATA_BASE + 4 * (248 + i)));
    end
    prog[PROG_LEN - 1] = encode_instr(OP_HALT, '0, '0, '0, '0);
  endtask

  task automatic run_model();
    word_t    regs [N_REGS];
    word_t    ins;
    word_t    imm;
    word_t    res;
    word_t    addr;
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     wr_rd;
    access_t  acc;
    for (int i = 0; i < int'(N_REGS); i++) begin
      regs[i] = '0;
    end
    for (int n = 0; n < PROG_LEN; n++) begin
      ins   = prog[n];
      op    = opcode_t'(ins[OPC_MSB:OPC_LSB]);
      rd    = ins[RD_MSB:RD_LSB];
      rs1   = ins[RS1_MSB:RS1_LSB];
      rs2   = ins[RS2_MSB:RS2_LSB];
      imm   = {{16{ins[IMM_MSB]}}, ins[IMM_MSB:IMM_LSB]};
      addr  = regs[rs1] + imm;
      wr_rd = 1'b1;
      res   = '0;
      case (op)
        OP_LI:  res = imm;
        OP_ADD: res = regs[rs1] + regs[rs2];
        OP_SUB: res = regs[rs1] - regs[rs2];
        OP_XOR: res = regs[rs1] ^ regs[rs2];
        OP_LW: begin
          res      = ref_mem[mem_index(addr)];
          acc.wr   = 1'b0;
          acc.addr = addr;
          acc.data = res;
          exp_q.push_back(acc);
        end
        OP_SW: begin
          wr_rd    = 1'b0;
          acc.wr   = 1'b1;
          acc.addr = addr;
          acc.data = regs[rs2];
          exp_q.push_back(acc);
          ref_mem[mem_index(addr)] = regs[rs2];
        end
        default: wr_rd = 1'b0;
      endcase
      // r0 is never written, so it keeps reading zero
      if (wr_rd && rd != '0) begin
        regs[rd] = res;
      end
    end
  endtask

  // ****************************************
  // Clock, buses, events, watchdog
  // ****************************************
  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  initial begin : instr_bus
    word_t exp_addr;
    forever begin
      @(negedge clk_i);
      instr_rvalid_i = 1'b0;
      if (instr_req_o) begin
        ibus_seed = lcg_next(ibus_seed);
        repeat ((ibus_seed >> 16) % 4) @(negedge clk_i);
        instr_gnt_i = 1'b1;
        if (fetch_cnt >= PROG_LEN) begin
          fail_now("instruction fetched after the end of the program");
        end
        exp_addr = BOOT_ADDR + word_t'(4 * fetch_cnt);
        check_word("instr_addr_o", instr_addr_o, exp_addr);
        check_bit("instr_wen_o", instr_wen_o, 1'b1);
        check_word("instr_be_o", word_t'(instr_be_o), word_t'(BE_ALL));
        fetch_cnt++;
        @(negedge clk_i);
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem[mem_index(exp_addr)];
      end
    end
  end

  initial begin : data_bus
    access_t acc;
    word_t   bus_addr;
    forever begin
      @(negedge clk_i);
      data_rvalid_i = 1'b0;
      if (data_req_o) begin
        dbus_seed = lcg_next(dbus_seed);
        repeat ((dbus_seed >> 16) % 4) @(negedge clk_i);
        data_gnt_i = 1'b1;
        if (exp_q.size() == 0) begin
          fail_now("data request beyond the accesses of the program");
        end
        acc = exp_q.pop_front();
        bus_addr = data_addr_o;
        check_bit("data_wen_o", data_wen_o, ~acc.wr);
        check_word("data_addr_o", bus_addr, acc.addr);
        check_word("data_be_o", word_t'(data_be_o), word_t'(BE_ALL));
        if (acc.wr) begin
          check_word("data_wdata_o", data_wdata_o, acc.data);
        end
        // Memory follows the bus, not the model
        if (!data_wen_o) begin
          mem[mem_index(bus_addr)] = data_wdata_o;
        end
        @(negedge clk_i);
        data_gnt_i    = 1'b0;
        data_rvalid_i = 1'b1;
        data_rdata_i  = mem[mem_index(bus_addr)];
      end
    end
  end

  initial begin : irq_events
    int unsigned burst_left;
    int unsigned r;
    burst_left = 0;
    forever begin
      @(negedge clk_i);
      // events_i still holds the value of the last edge
      if (core_irq_ack_o) begin
        if (events_i == '0) begin
          fail_now("interrupt acknowledged with no event at the previous edge");
        end
        check_irq_id("core_irq_ack_id_o", core_irq_ack_id_o, lowest_event(events_i));
      end
      evt_seed = lcg_next(evt_seed);
      if (burst_left != 0) begin
        burst_left--;
      end else if ((evt_seed >> 24) % 8 == 0) begin
        // Short burst of a sparse vector
        burst_left = 1 + (evt_seed >> 16) % 4;
        evt_seed = lcg_next(evt_seed);
        r = evt_seed;
        evt_seed = lcg_next(evt_seed);
        events_i = irq_vec_t'(r & evt_seed);
      end else begin
        events_i = '0;
      end
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clk_i);
    fail_now("watchdog expired before the program halted");
  end

  // ****************************************
  // Main sequence
  // ****************************************
  initial begin : main_seq
    rst_ni         = 1'b0;
    fetch_en_i     = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    events_i       = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(word_t'(i) << 2);
    end
    build_program();
    for (int n = 0; n < PROG_LEN; n++) begin
      mem[mem_index(BOOT_ADDR) + n] = prog[n];
    end
    ref_mem = mem;
    run_model();
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    // Quiet outputs before fetch enable
    @(negedge clk_i);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("data_req_o", data_req_o, 1'b0);
    check_bit("core_irq_ack_o", core_irq_ack_o, 1'b0);
    check_bit("stoptimer_o", stoptimer_o, 1'b0);
    fetch_en_i = 1'b1;
    while (!stoptimer_o) begin
      @(negedge clk_i);
    end
    // Halted core stays silent
    repeat (20) begin
      @(negedge clk_i);
      check_bit("stoptimer_o", stoptimer_o, 1'b1);
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_bit("data_req_o", data_req_o, 1'b0);
      check_bit("core_irq_ack_o", core_irq_ack_o, 1'b0);
    end
    check_word("instruction count", word_t'(fetch_cnt), word_t'(PROG_LEN));
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
    if (exp_q.size() != 0) begin
      fail_now("core halted with data accesses of the model still missing");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- compile.f
source/fc_pkg.sv
source/fc_irq_latch.sv
source/fc_fetch_port.sv
source/fc_data_port.sv
source/fc_exec_unit.sv
source/fc_core_ctrl.sv
source/fc_subsystem.sv
sim/fc_subsystem_assert.sv
sim/tb_fc_subsystem.sv

//--- Makefile
TOP = tb_fc_subsystem

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard source/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f compile.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
